// File: logic/smpc_cmd_pkg.sv
package smpc_cmd_pkg;

	localparam logic [7:0] CMD_MSHON   = 8'h00;
	localparam logic [7:0] CMD_SSHON   = 8'h02;
	localparam logic [7:0] CMD_SSHOFF  = 8'h03;
	localparam logic [7:0] CMD_SNDON   = 8'h06;
	localparam logic [7:0] CMD_SNDOFF  = 8'h07;
	localparam logic [7:0] CMD_CDON    = 8'h08;
	localparam logic [7:0] CMD_CDOFF   = 8'h09;
	localparam logic [7:0] CMD_INTBACK = 8'h10;
	localparam logic [7:0] CMD_SETTIME = 8'h16;
	localparam logic [7:0] CMD_RESENAB = 8'h19;
	localparam logic [7:0] CMD_RESDISA = 8'h1A;

	localparam logic [15:0] WAIT_PRE     = 16'd60;	// Lead-in before every command
	localparam logic [15:0] WAIT_SHORT   = 16'd60;
	localparam logic [15:0] WAIT_CD      = 16'd100;
	localparam logic [15:0] WAIT_TIME    = 16'd220;
	localparam logic [15:0] WAIT_INTBACK = 16'd740;

	typedef enum logic [3:0] {IDLE, WAIT, COMMAND, EXEC, DUMP, END} seq_state_e;

	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	localparam int         OREG_DEPTH         = 32;
	localparam logic [4:0] OREG_ECHO          = 5'd31;	// Always holds the command code
	localparam logic [7:0] SR_STATUS_DONE     = 8'h4F;
	localparam logic [7:0] INTBACK_STATUS_KEY = 8'hF0;

	// IREG0 is the year high byte for SETTIME, a flag byte for INTBACK
	typedef union packed {
		logic [7:0] year_hi;
		struct packed {
			logic       cont;
			logic       brk;
			logic [4:0] rsvd;
			logic       status_req;
		} intback;
	} ireg0_u;

endpackage

// File: logic/smpc_rtc_pkg.sv
package smpc_rtc_pkg;

	localparam logic [7:0] SEC_LAST  = 8'h59;
	localparam logic [7:0] MIN_LAST  = 8'h59;
	localparam logic [7:0] HOUR_LAST = 8'h23;

	localparam logic [7:0] DAYS_LAST_LONG  = 8'h31;
	localparam logic [7:0] DAYS_LAST_SHORT = 8'h30;
	localparam logic [7:0] DAYS_LAST_FEB   = 8'h28;	// No leap years

	localparam logic [3:0]      MONTH_FEB    = 4'd2;
	localparam logic [3:0]      MONTH_LAST   = 4'd12;
	localparam logic [3:0][3:0] SHORT_MONTHS = {4'd11, 4'd9, 4'd6, 4'd4};

	localparam logic [7:0]  DAYS_INIT  = 8'h01;
	localparam logic [3:0]  MONTH_INIT = 4'd1;
	localparam logic [3:0]  WDAY_INIT  = 4'd1;
	localparam logic [15:0] YEAR_INIT  = 16'h2024;

endpackage

// File: logic/smpc_cmd_if.sv
interface smpc_cmd_if;

	logic [7:0]           comreg;
	logic                 cmd_valid;	// One pulse per COMREG write
	smpc_cmd_pkg::ireg0_u ireg0;
	logic [7:0]           ireg1;
	logic [7:0]           ireg2;
	logic [7:0]           ireg3;
	logic [7:0]           ireg4;
	logic [7:0]           ireg5;
	logic [7:0]           ireg6;

	logic time_load;
	logic dump_req;
	logic echo_req;
	logic cmd_done;
	logic dump_done;

	logic ste;
	logic resd;
	logic sshres_n;
	logic sndres_n;
	logic cdres_n;

	modport host (output comreg, cmd_valid, ireg0, ireg1, ireg2, ireg3, ireg4, ireg5, ireg6,
		input cmd_done, dump_done);
	modport seq (input comreg, cmd_valid, ireg0, ireg2, dump_done,
		output time_load, dump_req, echo_req, cmd_done, ste, resd, sshres_n, sndres_n, cdres_n);
	modport rtc (input ireg0, ireg1, ireg2, ireg3, ireg4, ireg5, ireg6, time_load);
	modport oreg (input comreg, ste, resd, sshres_n, sndres_n, cdres_n, dump_req, echo_req,
		output dump_done);

endinterface

// File: logic/smpc_time_if.sv
interface smpc_time_if;

	logic [$bits(smpc_rtc_pkg::SEC_LAST)-1:0]       sec;
	logic [$bits(smpc_rtc_pkg::MIN_LAST)-1:0]       min;
	logic [$bits(smpc_rtc_pkg::HOUR_LAST)-1:0]      hour;
	logic [$bits(smpc_rtc_pkg::DAYS_INIT)-1:0]      days;
	logic [$bits(smpc_rtc_pkg::MONTH_INIT)*2-1:0]   wday_month;	// Weekday high, month low
	logic [$bits(smpc_rtc_pkg::YEAR_INIT)-1:0]      year;

	modport source (output sec, min, hour, days, wday_month, year);
	modport sink (input sec, min, hour, days, wday_month, year);

endinterface

// File: logic/smpc_host_regs.sv
module smpc_host_regs (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic [6:1]      a,
	input  logic [7:0]      di,
	input  logic            cs_n,
	input  logic            rw_n,
	output logic [7:0]      dout,
	smpc_cmd_if.host        cmd,
	input  logic [4:0]      oreg_wa,
	input  logic [7:0]      oreg_wd,
	input  logic            oreg_we,
	output logic            mirq_n
);

	logic [7:0] oreg_mem [smpc_cmd_pkg::OREG_DEPTH];
	logic [7:0] sr;
	logic       sf;
	logic       rw_n_old;
	logic       cs_n_old;
	logic [6:0] addr;
	logic [5:0] oreg_off;
	logic       wr_stb;
	logic       rd_stb;
	logic       com_wr;

	assign addr     = {a, 1'b1};
	assign oreg_off = a - smpc_cmd_pkg::ADDR_OREG_FIRST[6:1];
	assign wr_stb   = !rw_n && rw_n_old && !cs_n;	// Falling RW_N under chip select
	assign rd_stb   = !cs_n && cs_n_old && rw_n;
	assign com_wr   = wr_stb && addr == smpc_cmd_pkg::ADDR_COMREG;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old      <= 1'b1;
			cs_n_old      <= 1'b1;
			cmd.cmd_valid <= 1'b0;
			sf            <= 1'b0;
			sr            <= '0;
			mirq_n        <= 1'b1;
		end else begin
			rw_n_old      <= rw_n;
			cs_n_old      <= cs_n;
			cmd.cmd_valid <= com_wr;
			if (wr_stb && addr == smpc_cmd_pkg::ADDR_SF && di[0])
				sf <= 1'b1;	// Host set wins over a finishing command
			else if (cmd.cmd_done)
				sf <= 1'b0;
			if (cmd.dump_done) begin
				sr     <= smpc_cmd_pkg::SR_STATUS_DONE;
				mirq_n <= 1'b0;
			end else if (com_wr) begin
				mirq_n <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_stb) begin
			case (addr)
				smpc_cmd_pkg::ADDR_IREG0:          cmd.ireg0 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd2:   cmd.ireg1 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd4:   cmd.ireg2 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd6:   cmd.ireg3 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd8:   cmd.ireg4 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd10:  cmd.ireg5 <= di;
				smpc_cmd_pkg::ADDR_IREG0 + 7'd12:  cmd.ireg6 <= di;
				smpc_cmd_pkg::ADDR_COMREG:         cmd.comreg <= di;
				default: ;
			endcase
		end
		if (oreg_we)
			oreg_mem[oreg_wa] <= oreg_wd;
		if (rd_stb) begin
			if (addr >= smpc_cmd_pkg::ADDR_OREG_FIRST && addr <= smpc_cmd_pkg::ADDR_OREG_LAST)
				dout <= oreg_mem[oreg_off[4:0]];
			else if (addr == smpc_cmd_pkg::ADDR_SR)
				dout <= sr;
			else if (addr == smpc_cmd_pkg::ADDR_SF)
				dout <= {7'd0, sf};
			else
				dout <= 8'h00;
		end
	end

endmodule

// File: logic/smpc_rtc_counter.sv
module smpc_rtc_counter #(
	parameter int unsigned TICKS_PER_SEC = 4000000
) (
	input  logic        CLK,
	input  logic        RST_N,
	smpc_cmd_if.rtc     cmd,
	smpc_time_if.source tm
);

	localparam int DIV_W = $clog2(TICKS_PER_SEC + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       month;
	logic [7:0]       days_last;
	logic             sec_tick;
	logic             min_tick;
	logic             hour_tick;
	logic             day_tick;
	logic             month_tick;
	logic             year_tick;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		if (v == 8'h99)
			return 8'h00;
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return v + 8'd1;
	endfunction

	assign month      = tm.wday_month[3:0];
	assign sec_tick   = div_cnt == DIV_W'(TICKS_PER_SEC - 1);
	assign min_tick   = sec_tick && tm.sec == smpc_rtc_pkg::SEC_LAST;
	assign hour_tick  = min_tick && tm.min == smpc_rtc_pkg::MIN_LAST;
	assign day_tick   = hour_tick && tm.hour == smpc_rtc_pkg::HOUR_LAST;
	assign month_tick = day_tick && tm.days == days_last;
	assign year_tick  = month_tick && month == smpc_rtc_pkg::MONTH_LAST;

	always_comb begin
		days_last = smpc_rtc_pkg::DAYS_LAST_LONG;
		if (month == smpc_rtc_pkg::MONTH_FEB)
			days_last = smpc_rtc_pkg::DAYS_LAST_FEB;
		for (int i = 0; i < 4; i++)
			if (month == smpc_rtc_pkg::SHORT_MONTHS[i])
				days_last = smpc_rtc_pkg::DAYS_LAST_SHORT;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt       <= '0;
			tm.sec        <= '0;
			tm.min        <= '0;
			tm.hour       <= '0;
			tm.days       <= smpc_rtc_pkg::DAYS_INIT;
			tm.wday_month <= {smpc_rtc_pkg::WDAY_INIT, smpc_rtc_pkg::MONTH_INIT};
			tm.year       <= smpc_rtc_pkg::YEAR_INIT;
		end else if (cmd.time_load) begin
			div_cnt       <= '0;	// Restart the second
			tm.year       <= {cmd.ireg0.year_hi, cmd.ireg1};
			tm.wday_month <= cmd.ireg2;
			tm.days       <= cmd.ireg3;
			tm.hour       <= cmd.ireg4;
			tm.min        <= cmd.ireg5;
			tm.sec        <= cmd.ireg6;
		end else begin
			div_cnt <= sec_tick ? '0 : div_cnt + 1'b1;
			if (sec_tick)
				tm.sec <= min_tick ? 8'h00 : bcd_inc(tm.sec);
			if (min_tick)
				tm.min <= hour_tick ? 8'h00 : bcd_inc(tm.min);
			if (hour_tick)
				tm.hour <= day_tick ? 8'h00 : bcd_inc(tm.hour);
			if (day_tick)
				tm.days <= month_tick ? smpc_rtc_pkg::DAYS_INIT : bcd_inc(tm.days);
			if (month_tick)
				tm.wday_month[3:0] <= year_tick ? smpc_rtc_pkg::MONTH_INIT : month + 4'd1;
			if (year_tick) begin
				tm.year[7:0] <= bcd_inc(tm.year[7:0]);
				if (tm.year[7:0] == 8'h99)
					tm.year[15:8] <= bcd_inc(tm.year[15:8]);	// Century digits
			end
		end
	end

endmodule

// File: logic/smpc_cmd_sequencer.sv
module smpc_cmd_sequencer (
	input  logic    CLK,
	input  logic    RST_N,
	smpc_cmd_if.seq cmd,
	output logic    mshres_n,
	output logic    sshres_n,
	output logic    sndres_n,
	output logic    cdres_n
);

	smpc_cmd_pkg::seq_state_e state;
	smpc_cmd_pkg::seq_state_e next_state;
	logic [7:0]  cur_cmd;
	logic [15:0] wait_cnt;
	logic [15:0] grp_wait;
	logic        pending;
	logic        status_ok;
	logic        run;

	assign status_ok = cmd.ireg0.intback.status_req &&
		cmd.ireg2 == smpc_cmd_pkg::INTBACK_STATUS_KEY;

	always_comb begin
		grp_wait = smpc_cmd_pkg::WAIT_SHORT;
		run      = 1'b1;
		case (cur_cmd)
			smpc_cmd_pkg::CMD_CDON, smpc_cmd_pkg::CMD_CDOFF: grp_wait = smpc_cmd_pkg::WAIT_CD;
			smpc_cmd_pkg::CMD_SETTIME: grp_wait = smpc_cmd_pkg::WAIT_TIME;
			smpc_cmd_pkg::CMD_INTBACK: begin
				grp_wait = smpc_cmd_pkg::WAIT_INTBACK;
				run      = status_ok;
			end
			smpc_cmd_pkg::CMD_MSHON, smpc_cmd_pkg::CMD_SSHON, smpc_cmd_pkg::CMD_SSHOFF,
			smpc_cmd_pkg::CMD_SNDON, smpc_cmd_pkg::CMD_SNDOFF,
			smpc_cmd_pkg::CMD_RESENAB, smpc_cmd_pkg::CMD_RESDISA: ;
			default: run = 1'b0;	// Unknown code ends at once
		endcase
	end

	assign cmd.time_load = state == smpc_cmd_pkg::EXEC && cur_cmd == smpc_cmd_pkg::CMD_SETTIME;
	assign cmd.dump_req  = state == smpc_cmd_pkg::EXEC && cur_cmd == smpc_cmd_pkg::CMD_INTBACK;
	assign cmd.echo_req  = state == smpc_cmd_pkg::EXEC && cur_cmd != smpc_cmd_pkg::CMD_INTBACK;
	assign cmd.cmd_done  = state == smpc_cmd_pkg::END;
	assign cmd.sshres_n  = sshres_n;
	assign cmd.sndres_n  = sndres_n;
	assign cmd.cdres_n   = cdres_n;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= smpc_cmd_pkg::IDLE;
			next_state <= smpc_cmd_pkg::IDLE;
			cur_cmd    <= '0;
			wait_cnt   <= '0;
			pending    <= 1'b0;
			mshres_n   <= 1'b0;
			sshres_n   <= 1'b0;
			sndres_n   <= 1'b0;
			cdres_n    <= 1'b0;
			cmd.ste    <= 1'b0;
			cmd.resd   <= 1'b1;
		end else begin
			if (cmd.cmd_valid)
				pending <= 1'b1;	// Held until the FSM is idle
			case (state)
				smpc_cmd_pkg::IDLE: if (pending || cmd.cmd_valid) begin
					pending    <= 1'b0;
					cur_cmd    <= cmd.comreg;
					wait_cnt   <= smpc_cmd_pkg::WAIT_PRE - 16'd2;	// Entry and exit cycles
					next_state <= smpc_cmd_pkg::COMMAND;
					state      <= smpc_cmd_pkg::WAIT;
				end
				smpc_cmd_pkg::WAIT: begin
					if (wait_cnt == 16'd0)
						state <= next_state;
					else
						wait_cnt <= wait_cnt - 16'd1;
				end
				smpc_cmd_pkg::COMMAND: begin
					if (run) begin
						wait_cnt   <= grp_wait - 16'd2;
						next_state <= smpc_cmd_pkg::EXEC;
						state      <= smpc_cmd_pkg::WAIT;
					end else begin
						state <= smpc_cmd_pkg::END;
					end
				end
				smpc_cmd_pkg::EXEC: begin
					state <= smpc_cmd_pkg::END;
					case (cur_cmd)
						smpc_cmd_pkg::CMD_MSHON:   mshres_n <= 1'b1;
						smpc_cmd_pkg::CMD_SSHON:   sshres_n <= 1'b1;
						smpc_cmd_pkg::CMD_SSHOFF:  sshres_n <= 1'b0;
						smpc_cmd_pkg::CMD_SNDON:   sndres_n <= 1'b1;
						smpc_cmd_pkg::CMD_SNDOFF:  sndres_n <= 1'b0;
						smpc_cmd_pkg::CMD_CDON:    cdres_n  <= 1'b1;
						smpc_cmd_pkg::CMD_CDOFF:   cdres_n  <= 1'b0;
						smpc_cmd_pkg::CMD_SETTIME: cmd.ste  <= 1'b1;
						smpc_cmd_pkg::CMD_RESENAB: cmd.resd <= 1'b0;
						smpc_cmd_pkg::CMD_RESDISA: cmd.resd <= 1'b1;
						smpc_cmd_pkg::CMD_INTBACK: state    <= smpc_cmd_pkg::DUMP;
						default: ;
					endcase
				end
				smpc_cmd_pkg::DUMP: if (cmd.dump_done)
					state <= smpc_cmd_pkg::END;
				smpc_cmd_pkg::END: state <= smpc_cmd_pkg::IDLE;
				default: state <= smpc_cmd_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: logic/smpc_oreg_builder.sv
module smpc_oreg_builder (
	input  logic        CLK,
	input  logic        RST_N,
	smpc_cmd_if.oreg    cmd,
	smpc_time_if.sink   tm,
	input  logic [3:0]  ac,
	output logic [4:0]  oreg_wa,
	output logic [7:0]  oreg_wd,
	output logic        oreg_we
);

	logic       busy;
	logic [4:0] cnt;
	logic [7:0] entry;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (cmd.dump_req) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + 5'd1;
			if (cmd.dump_done)
				busy <= 1'b0;
		end
	end

	always_comb begin
		case (cnt)
			5'd0:  entry = {cmd.ste, cmd.resd, 6'd0};
			5'd1:  entry = tm.year[15:8];
			5'd2:  entry = tm.year[7:0];
			5'd3:  entry = tm.wday_month;
			5'd4:  entry = tm.days;
			5'd5:  entry = tm.hour;
			5'd6:  entry = tm.min;
			5'd7:  entry = tm.sec;
			5'd9:  entry = {4'd0, ac};
			5'd10: entry = 8'h30 | {6'd0, ~cmd.sshres_n, ~cmd.sndres_n};
			5'd11: entry = {1'b0, ~cmd.cdres_n, 6'd0};
			smpc_cmd_pkg::OREG_ECHO: entry = cmd.comreg;
			default: entry = 8'h00;
		endcase
	end

	assign cmd.dump_done = busy && cnt == 5'(smpc_cmd_pkg::OREG_DEPTH - 1);
	assign oreg_we = busy || cmd.echo_req;	// Echo and dump never overlap
	assign oreg_wa = busy ? cnt : smpc_cmd_pkg::OREG_ECHO;
	assign oreg_wd = busy ? entry : cmd.comreg;

endmodule

// File: logic/smpc_top.sv
module smpc_top #(
	parameter int unsigned TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [6:1] a,
	input  logic [7:0] di,
	input  logic       cs_n,
	input  logic       rw_n,
	output logic [7:0] dout,
	input  logic [3:0] ac,
	output logic       mshres_n,
	output logic       sshres_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);

	logic [4:0] oreg_wa;
	logic [7:0] oreg_wd;
	logic       oreg_we;

	smpc_cmd_if  u_cmd_if ();
	smpc_time_if u_time_if ();

	smpc_host_regs u_host_regs (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n), .dout(dout),
		.cmd(u_cmd_if.host), .oreg_wa(oreg_wa), .oreg_wd(oreg_wd), .oreg_we(oreg_we),
		.mirq_n(mirq_n)
	);

	smpc_rtc_counter #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_rtc_counter (
		.CLK(CLK), .RST_N(RST_N), .cmd(u_cmd_if.rtc), .tm(u_time_if.source)
	);

	smpc_cmd_sequencer u_cmd_sequencer (
		.CLK(CLK), .RST_N(RST_N), .cmd(u_cmd_if.seq), .mshres_n(mshres_n),
		.sshres_n(sshres_n), .sndres_n(sndres_n), .cdres_n(cdres_n)
	);

	smpc_oreg_builder u_oreg_builder (
		.CLK(CLK), .RST_N(RST_N), .cmd(u_cmd_if.oreg), .tm(u_time_if.sink), .ac(ac),
		.oreg_wa(oreg_wa), .oreg_wd(oreg_wd), .oreg_we(oreg_we)
	);

endmodule

// File: testbench/smpc_chk.sv
module smpc_chk (
	input logic       CLK,
	input logic       RST_N,
	input logic       mirq_n,
	input logic       sf,
	input logic       dump_busy,
	input logic       oreg_we,
	input logic [4:0] oreg_wa
);

	assert property (@(posedge CLK) $rose(RST_N) |-> mirq_n)
		else $error("mirq_n low right after reset");

	assert property (@(posedge CLK) disable iff (!RST_N) (oreg_we && dump_busy) |=> !$rose(sf))
		else $error("SF set in the cycle of a dump write");

	// Dump walks the output file one entry per cycle
	assert property (@(posedge CLK) disable iff (!RST_N)
		(oreg_we && dump_busy && oreg_wa != 5'(smpc_cmd_pkg::OREG_DEPTH - 1))
		|=> (oreg_we && oreg_wa == $past(oreg_wa) + 5'd1))
		else $error("Dump skipped an output register entry");

endmodule

bind smpc_top smpc_chk u_chk (
	.CLK(CLK), .RST_N(RST_N), .mirq_n(mirq_n), .sf(u_host_regs.sf),
	.dump_busy(u_oreg_builder.busy), .oreg_we(oreg_we), .oreg_wa(oreg_wa)
);

// File: testbench/smpc_tb.sv
module smpc_tb;

	localparam int          NUM_ROWS   = 10;
	localparam int          POLL_LIMIT = 2000;	// SF reads per command
	localparam int          IDLE_GAP   = 40;
	localparam logic [3:0]  AC_VALUE   = 4'h5;
	localparam logic [55:0] IREGS_NONE = 56'd0;
	// ireg6 down to ireg0
	localparam logic [55:0] IREGS_SETTIME = {8'h58, 8'h59, 8'h23, 8'h31, 8'h0C, 8'h23, 8'h20};
	localparam logic [55:0] IREGS_STATUS  = {32'd0, 8'hF0, 8'h00, 8'h01};
	localparam logic [55:0] IREGS_BAD_KEY = {32'd0, 8'h00, 8'h00, 8'h01};

	typedef struct packed {
		logic [7:0]  code;
		logic [55:0] iregs;
		logic [3:0]  lines;	// msh, ssh, snd, cd
		logic [7:0]  echo;
	} cmd_row_t;

	logic       CLK = 1'b0;
	logic       RST_N;
	logic [6:1] a;
	logic [7:0] di;
	logic       cs_n;
	logic       rw_n;
	logic [7:0] dout;
	logic [3:0] ac;
	logic       mshres_n;
	logic       sshres_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;

	cmd_row_t    rows [NUM_ROWS];
	logic [7:0]  dump_bytes [smpc_cmd_pkg::OREG_DEPTH];
	logic [3:0]  exp_lines;
	logic [7:0]  rd_val;
	int unsigned cycles = 0;
	int unsigned t_start;
	int unsigned t_end;
	int          checks = 0;
	int          errors = 0;

	// Reference clock model
	logic [15:0] m_year;
	logic [7:0]  m_wday_month;
	logic [7:0]  m_days;
	logic [7:0]  m_hour;
	logic [7:0]  m_min;
	logic [7:0]  m_sec;

	smpc_top #(.TICKS_PER_SEC(4)) u_smpc_top (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n), .dout(dout),
		.ac(ac), .mshres_n(mshres_n), .sshres_n(sshres_n), .sndres_n(sndres_n),
		.cdres_n(cdres_n), .mirq_n(mirq_n)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK)
		cycles <= cycles + 1;

	task automatic fill_table();
		rows[0] = {smpc_cmd_pkg::CMD_MSHON, IREGS_NONE, 4'b1000, smpc_cmd_pkg::CMD_MSHON};
		rows[1] = {smpc_cmd_pkg::CMD_SSHON, IREGS_NONE, 4'b1100, smpc_cmd_pkg::CMD_SSHON};
		rows[2] = {smpc_cmd_pkg::CMD_SNDON, IREGS_NONE, 4'b1110, smpc_cmd_pkg::CMD_SNDON};
		rows[3] = {smpc_cmd_pkg::CMD_CDON, IREGS_NONE, 4'b1111, smpc_cmd_pkg::CMD_CDON};
		rows[4] = {smpc_cmd_pkg::CMD_SSHOFF, IREGS_NONE, 4'b1011, smpc_cmd_pkg::CMD_SSHOFF};
		rows[5] = {smpc_cmd_pkg::CMD_SNDOFF, IREGS_NONE, 4'b1001, smpc_cmd_pkg::CMD_SNDOFF};
		rows[6] = {smpc_cmd_pkg::CMD_CDOFF, IREGS_NONE, 4'b1000, smpc_cmd_pkg::CMD_CDOFF};
		rows[7] = {smpc_cmd_pkg::CMD_SNDON, IREGS_NONE, 4'b1010, smpc_cmd_pkg::CMD_SNDON};
		rows[8] = {smpc_cmd_pkg::CMD_RESDISA, IREGS_NONE, 4'b1010, smpc_cmd_pkg::CMD_RESDISA};
		rows[9] = {smpc_cmd_pkg::CMD_RESENAB, IREGS_NONE, 4'b1010, smpc_cmd_pkg::CMD_RESENAB};
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic expect_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// One cycle with both strobes low gives the RW_N fall under chip select
	task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
		@(posedge CLK);
		a    <= addr[6:1];
		di   <= data;
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		@(posedge CLK);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
		@(posedge CLK);
		a    <= addr[6:1];
		cs_n <= 1'b0;
		rw_n <= 1'b1;
		@(posedge CLK);
		cs_n <= 1'b1;
		@(negedge CLK);
		data = dout;
	endtask

	task automatic read_dump();
		for (int i = 0; i < smpc_cmd_pkg::OREG_DEPTH; i++)
			read_reg(smpc_cmd_pkg::ADDR_OREG_FIRST + 7'(2 * i), dump_bytes[i]);
	endtask

	task automatic run_command(input logic [7:0] code, input logic [55:0] iregs);
		int         polls;
		logic [7:0] sf_val;
		for (int i = 0; i < 7; i++)
			write_reg(smpc_cmd_pkg::ADDR_IREG0 + 7'(2 * i), iregs[8 * i +: 8]);
		write_reg(smpc_cmd_pkg::ADDR_SF, 8'h01);
		write_reg(smpc_cmd_pkg::ADDR_COMREG, code);
		polls  = 0;
		sf_val = 8'h01;
		while (sf_val[0] && polls < POLL_LIMIT) begin
			read_reg(smpc_cmd_pkg::ADDR_SF, sf_val);
			polls++;
		end
		if (sf_val[0]) begin
			errors++;
			$display("Timeout: SF still set after %0d reads for command %02h", polls, code);
			finish_run();
		end
	endtask

	function automatic logic [7:0] bcd_next(input logic [7:0] v);
		int n;
		n = (v[7:4] * 10 + v[3:0] + 1) % 100;
		return {4'(n / 10), 4'(n % 10)};
	endfunction

	function automatic logic [7:0] month_last_day(input logic [3:0] m);
		if (m == smpc_rtc_pkg::MONTH_FEB)
			return smpc_rtc_pkg::DAYS_LAST_FEB;
		if (m == 4'd4 || m == 4'd6 || m == 4'd9 || m == 4'd11)
			return smpc_rtc_pkg::DAYS_LAST_SHORT;
		return smpc_rtc_pkg::DAYS_LAST_LONG;
	endfunction

	function automatic logic [47:0] model_upper();
		return {m_year, m_wday_month, m_days, m_hour, m_min};
	endfunction

	task automatic tick_model();
		if (m_sec != smpc_rtc_pkg::SEC_LAST) begin
			m_sec = bcd_next(m_sec);
		end else begin
			m_sec = 8'h00;
			if (m_min != smpc_rtc_pkg::MIN_LAST) begin
				m_min = bcd_next(m_min);
			end else begin
				m_min = 8'h00;
				if (m_hour != smpc_rtc_pkg::HOUR_LAST) begin
					m_hour = bcd_next(m_hour);
				end else begin
					m_hour = 8'h00;
					if (m_days != month_last_day(m_wday_month[3:0])) begin
						m_days = bcd_next(m_days);
					end else begin
						m_days = smpc_rtc_pkg::DAYS_INIT;
						if (m_wday_month[3:0] != smpc_rtc_pkg::MONTH_LAST) begin
							m_wday_month[3:0] = m_wday_month[3:0] + 4'd1;
						end else begin
							m_wday_month[3:0] = smpc_rtc_pkg::MONTH_INIT;
							if (m_year[7:0] == 8'h99)
								m_year[15:8] = bcd_next(m_year[15:8]);
							m_year[7:0] = bcd_next(m_year[7:0]);
						end
					end
				end
			end
		end
	endtask

	// Seconds entry is captured last, so it may lead the other fields by one tick
	task automatic check_clock(input int unsigned k_max);
		logic [47:0] got_upper;
		logic [47:0] prev_upper;
		logic        found;
		got_upper = {dump_bytes[1], dump_bytes[2], dump_bytes[3], dump_bytes[4],
			dump_bytes[5], dump_bytes[6]};
		m_year       = 16'h2023;
		m_wday_month = 8'h0C;
		m_days       = 8'h31;
		m_hour       = 8'h23;
		m_min        = 8'h59;
		m_sec        = 8'h58;
		prev_upper   = model_upper();
		found        = 1'b0;
		for (int unsigned k = 0; k <= k_max && !found; k++) begin
			if (dump_bytes[7] == m_sec && (got_upper == model_upper() || got_upper == prev_upper))
				found = 1'b1;
			prev_upper = model_upper();
			tick_model();
		end
		checks++;
		assert (found) else begin
			errors++;
			$display("[ERROR] %0t: dumped time %02h%02h-%02h-%02h %02h:%02h:%02h fits no k <= %0d",
				$time, dump_bytes[1], dump_bytes[2], dump_bytes[3], dump_bytes[4],
				dump_bytes[5], dump_bytes[6], dump_bytes[7], k_max);
		end
		expect_byte("year high", dump_bytes[1], 8'h20);
		expect_byte("year low", dump_bytes[2], 8'h24);
		expect_byte("month", {4'd0, dump_bytes[3][3:0]}, 8'h01);
		expect_byte("day", dump_bytes[4], 8'h01);
		expect_byte("hour", dump_bytes[5], 8'h00);
	endtask

	task automatic check_status_dump(input logic [7:0] exp_flags);
		logic [7:0] exp;
		for (int i = 0; i < smpc_cmd_pkg::OREG_DEPTH; i++) begin
			if (i < 1 || i > 7) begin
				case (i)
					0:       exp = exp_flags;
					9:       exp = {4'd0, AC_VALUE};
					10:      exp = 8'h30 | {6'd0, ~exp_lines[2], ~exp_lines[1]};
					11:      exp = {1'b0, ~exp_lines[0], 6'd0};
					31:      exp = smpc_cmd_pkg::CMD_INTBACK;
					default: exp = 8'h00;
				endcase
				expect_byte($sformatf("OREG%0d", i), dump_bytes[i], exp);
			end
		end
	endtask

	initial begin
		fill_table();
		RST_N <= 1'b0;
		a     <= '0;
		di    <= '0;
		cs_n  <= 1'b1;
		rw_n  <= 1'b1;
		ac    <= AC_VALUE;
		repeat (5) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);

		expect_byte("reset lines", {4'd0, mshres_n, sshres_n, sndres_n, cdres_n}, 8'h00);
		expect_byte("mirq_n after reset", {7'd0, mirq_n}, 8'h01);
		read_reg(smpc_cmd_pkg::ADDR_SF, rd_val);
		expect_byte("SF after reset", rd_val, 8'h00);
		read_reg(smpc_cmd_pkg::ADDR_SR, rd_val);
		expect_byte("SR after reset", rd_val, 8'h00);

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_command(rows[r].code, rows[r].iregs);
			expect_byte($sformatf("lines after %02h", rows[r].code),
				{4'd0, mshres_n, sshres_n, sndres_n, cdres_n}, {4'd0, rows[r].lines});
			read_reg(smpc_cmd_pkg::ADDR_OREG_LAST, rd_val);
			expect_byte($sformatf("OREG31 after %02h", rows[r].code), rd_val, rows[r].echo);
			exp_lines = rows[r].lines;
		end

		// Wrong key ends without a dump, SR keeps its reset value
		run_command(smpc_cmd_pkg::CMD_INTBACK, IREGS_BAD_KEY);
		expect_byte("mirq_n after bad INTBACK", {7'd0, mirq_n}, 8'h01);
		read_reg(smpc_cmd_pkg::ADDR_SR, rd_val);
		expect_byte("SR after bad INTBACK", rd_val, 8'h00);

		// Clock set just before a year wrap
		t_start = cycles;
		run_command(smpc_cmd_pkg::CMD_SETTIME, IREGS_SETTIME);
		repeat (IDLE_GAP) @(posedge CLK);
		run_command(smpc_cmd_pkg::CMD_INTBACK, IREGS_STATUS);
		t_end = cycles;
		read_dump();
		check_status_dump(8'h80);	// ste set, resd cleared by RESENAB
		check_clock((t_end - t_start) / 4 + 1);
		read_reg(smpc_cmd_pkg::ADDR_SR, rd_val);
		expect_byte("SR after dump", rd_val, smpc_cmd_pkg::SR_STATUS_DONE);
		expect_byte("mirq_n after dump", {7'd0, mirq_n}, 8'h00);

		run_command(smpc_cmd_pkg::CMD_RESDISA, IREGS_NONE);
		expect_byte("mirq_n after next command", {7'd0, mirq_n}, 8'h01);
		run_command(smpc_cmd_pkg::CMD_INTBACK, IREGS_STATUS);
		read_dump();
		check_status_dump(8'hC0);
		expect_byte("mirq_n after second dump", {7'd0, mirq_n}, 8'h00);
		finish_run();
	end

endmodule

// File: flist.f
logic/smpc_cmd_pkg.sv
logic/smpc_rtc_pkg.sv
logic/smpc_cmd_if.sv
logic/smpc_time_if.sv
logic/smpc_host_regs.sv
logic/smpc_rtc_counter.sv
logic/smpc_cmd_sequencer.sv
logic/smpc_oreg_builder.sv
logic/smpc_top.sv
testbench/smpc_chk.sv
testbench/smpc_tb.sv

// File: Bender.yml
package:
  name: smpc

sources:
  - logic/smpc_cmd_pkg.sv
  - logic/smpc_rtc_pkg.sv
  - logic/smpc_cmd_if.sv
  - logic/smpc_time_if.sv
  - logic/smpc_host_regs.sv
  - logic/smpc_rtc_counter.sv
  - logic/smpc_cmd_sequencer.sv
  - logic/smpc_oreg_builder.sv
  - logic/smpc_top.sv
  - target: simulation
    files:
      - testbench/smpc_chk.sv
      - testbench/smpc_tb.sv
